/* deskew_state.sv */
`timescale 1ns/10ps
`default_nettype none

module deskew_state (
  input  logic     mgt_clk,
  input  logic     reset,
  lane_bus_if.sink lanes,
  output logic     align_status,
  output logic     enable_deskew
);

  xaui_pkg::align_state_t state;
  xaui_pkg::align_state_t state_next;
  logic                   got_align;
  logic                   align_error;

  assign got_align   = (&lanes.charisk) &&
                       (lanes.data == {xaui_pkg::lane_count{xaui_pkg::sym_a}});
  assign align_error = |lanes.disp_err;

  // ------------------------------
  // Next state
  // ------------------------------

  always_comb begin
    state_next = state;
    if (lanes.sync_status != '1) begin
      state_next = xaui_pkg::loss_of_alignment; // Any lane out of sync
    end else begin
      case (state)
        xaui_pkg::loss_of_alignment: begin
          if (got_align) state_next = xaui_pkg::align_detect_1;
        end
        xaui_pkg::align_detect_1: begin
          if (got_align) state_next = xaui_pkg::align_detect_2;
          else if (align_error) state_next = xaui_pkg::loss_of_alignment;
        end
        xaui_pkg::align_detect_2: begin
          if (got_align) state_next = xaui_pkg::align_detect_3;
          else if (align_error) state_next = xaui_pkg::loss_of_alignment;
        end
        xaui_pkg::align_detect_3: begin
          if (got_align) state_next = xaui_pkg::align_acquired_1;
          else if (align_error) state_next = xaui_pkg::loss_of_alignment;
        end
        xaui_pkg::align_acquired_1: begin
          if (align_error) state_next = xaui_pkg::align_acquired_2;
        end
        xaui_pkg::align_acquired_2: begin
          if (align_error) state_next = xaui_pkg::align_acquired_3;
          else if (got_align) state_next = xaui_pkg::align_acquired_1;
        end
        xaui_pkg::align_acquired_3: begin
          if (align_error) state_next = xaui_pkg::align_acquired_4;
          else if (got_align) state_next = xaui_pkg::align_acquired_2;
        end
        xaui_pkg::align_acquired_4: begin
          if (align_error) state_next = xaui_pkg::loss_of_alignment;
          else if (got_align) state_next = xaui_pkg::align_acquired_3;
        end
        default: begin
          state_next = xaui_pkg::loss_of_alignment;
        end
      endcase
    end
  end

  // ------------------------------
  // State and decoded outputs
  // ------------------------------

  always_ff @(posedge mgt_clk) begin
    if (reset) begin
      state         <= xaui_pkg::loss_of_alignment;
      align_status  <= 1'b0;
      enable_deskew <= 1'b1;
    end else begin
      state         <= state_next;
      align_status  <= state inside {xaui_pkg::align_acquired_1, xaui_pkg::align_acquired_2,
                                     xaui_pkg::align_acquired_3, xaui_pkg::align_acquired_4};
      enable_deskew <= (state == xaui_pkg::loss_of_alignment); // Lags the state by a cycle
    end
  end

endmodule

`default_nettype wire

/* lane_bus_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Four byte lanes with their per-lane status flags
interface lane_bus_if;

  xaui_pkg::lane_word_t  data;
  xaui_pkg::lane_flags_t charisk;     // K flag per lane
  xaui_pkg::lane_flags_t disp_err;    // Disparity error per lane
  xaui_pkg::lane_flags_t sync_status; // Code-group sync per lane

  modport source (
    output data,
    output charisk,
    output disp_err,
    output sync_status
  );

  modport sink (
    input data,
    input charisk,
    input disp_err,
    input sync_status
  );

endinterface

`default_nettype wire

/* lane_deskew.sv */
`timescale 1ns/10ps
`default_nettype none

module lane_deskew (
  input  logic       mgt_clk,
  input  logic       reset,
  input  logic       enable_deskew,
  lane_bus_if.sink   raw,
  lane_bus_if.source aligned
);

  xaui_pkg::lane_word_t  data_dly [0:xaui_pkg::max_skew];
  xaui_pkg::lane_flags_t k_dly    [0:xaui_pkg::max_skew];
  xaui_pkg::lane_flags_t err_dly  [0:xaui_pkg::max_skew];

  xaui_pkg::lane_delay_t lane_delay [xaui_pkg::lane_count];
  xaui_pkg::lane_delay_t arrival    [xaui_pkg::lane_count];

  xaui_pkg::lane_flags_t a_hit;
  xaui_pkg::lane_flags_t seen;
  xaui_pkg::lane_flags_t seen_next;
  xaui_pkg::lane_delay_t win_cnt;
  xaui_pkg::lane_delay_t win_pos;
  xaui_pkg::lane_delay_t latest;
  logic                  win_active;

  // ------------------------------
  // Delay lines
  // ------------------------------

  // Stage 0 is the registered input, stage n adds n more cycles
  always_ff @(posedge mgt_clk) begin
    data_dly[0] <= raw.data;
    for (int s = 1; s <= xaui_pkg::max_skew; s++) begin
      data_dly[s] <= data_dly[s-1];
    end
  end

  always_ff @(posedge mgt_clk) begin
    if (reset) begin
      for (int s = 0; s <= xaui_pkg::max_skew; s++) begin
        k_dly[s]   <= '0;
        err_dly[s] <= '0;
      end
      aligned.sync_status <= '0;
    end else begin
      k_dly[0]   <= raw.charisk;
      err_dly[0] <= raw.disp_err;
      for (int s = 1; s <= xaui_pkg::max_skew; s++) begin
        k_dly[s]   <= k_dly[s-1];
        err_dly[s] <= err_dly[s-1];
      end
      aligned.sync_status <= raw.sync_status; // Not delayed with the lanes
    end
  end

  // Each lane taps the stage picked by its own delay
  always_comb begin
    for (int i = 0; i < xaui_pkg::lane_count; i++) begin
      aligned.data[8*i +: 8] = data_dly[lane_delay[i]][8*i +: 8];
      aligned.charisk[i]     = k_dly[lane_delay[i]][i];
      aligned.disp_err[i]    = err_dly[lane_delay[i]][i];
    end
  end

  // ------------------------------
  // Skew measurement
  // ------------------------------

  always_comb begin
    for (int i = 0; i < xaui_pkg::lane_count; i++) begin
      a_hit[i] = raw.charisk[i] && (raw.data[8*i +: 8] == xaui_pkg::sym_a);
    end
  end

  assign win_pos   = win_active ? win_cnt : '0; // Offset of the current cycle in the window
  assign seen_next = seen | a_hit;

  // The last lane to show /A/ sets the reference point
  always_comb begin
    latest = '0;
    for (int i = 0; i < xaui_pkg::lane_count; i++) begin
      if (arrival[i] > latest) begin
        latest = arrival[i];
      end
    end
  end

  // Only the first /A/ of a lane inside a window is kept
  always_ff @(posedge mgt_clk) begin
    for (int i = 0; i < xaui_pkg::lane_count; i++) begin
      if (a_hit[i] && !seen[i]) begin
        arrival[i] <= win_pos;
      end
    end
  end

  always_ff @(posedge mgt_clk) begin
    if (reset) begin
      win_active <= 1'b0;
      win_cnt    <= '0;
      seen       <= '0;
      for (int i = 0; i < xaui_pkg::lane_count; i++) begin
        lane_delay[i] <= '0;
      end
    end else if (!enable_deskew) begin
      win_active <= 1'b0; // Delays hold while the FSM is aligned
      seen       <= '0;
    end else if (&seen) begin
      for (int i = 0; i < xaui_pkg::lane_count; i++) begin
        lane_delay[i] <= latest - arrival[i]; // Early lanes wait for the latest one
      end
      win_active <= 1'b0;
      seen       <= '0;
    end else if (win_active || (|a_hit)) begin
      if (win_active && win_cnt == xaui_pkg::max_skew && !(&seen_next)) begin
        win_active <= 1'b0; // Window ran out with a lane missing
        seen       <= '0;
      end else begin
        win_active <= 1'b1;
        win_cnt    <= win_pos + 1'b1;
        seen       <= seen_next;
      end
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the lane alignment testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f xaui_rx_align.f \
  --top-module tb_xaui_rx_align \
  -o sim_tb_xaui_rx_align
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb_xaui_rx_align 2>&1)
echo "$output"

if echo "$output" | grep -q "^No errors$"; then
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

/* tb_xaui_rx_align.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_xaui_rx_align;

  localparam int cycle_limit = 6 * 20 * 16 + 80; // Six tests of 20 /A/ periods plus margin

  logic                  mgt_clk = 1'b0;
  logic                  reset = 1'b1;
  xaui_pkg::lane_word_t  mgt_rxdata = '0;
  xaui_pkg::lane_flags_t mgt_rxcharisk = '0;
  xaui_pkg::lane_flags_t mgt_sync_status = '0;
  xaui_pkg::lane_flags_t mgt_disp_err = '0;
  xaui_pkg::lane_word_t  rx_data;
  xaui_pkg::lane_flags_t rx_charisk;
  logic                  align_status;

  logic [15:0]           lfsr = 16'd62718;
  xaui_pkg::lane_word_t  hist_d [0:7];
  xaui_pkg::lane_flags_t hist_k [0:7];
  int                    skew [xaui_pkg::lane_count];
  logic [35:0]           exp_q [$];
  int                    col_pos = 0;
  int                    a_sent = 0;
  int                    cyc = 0;
  bit                    synced = 0;
  bit                    hold_high = 0;
  bit                    hold_low = 0;
  bit                    err_req = 0;
  bit                    sync_req = 0;
  logic [1:0]            sync_lane = '0;
  string                 test_name = "reset";

  xaui_rx_align u_xaui_rx_align (
    .mgt_clk         (mgt_clk),
    .reset           (reset),
    .mgt_rxdata      (mgt_rxdata),
    .mgt_rxcharisk   (mgt_rxcharisk),
    .mgt_sync_status (mgt_sync_status),
    .mgt_disp_err    (mgt_disp_err),
    .rx_data         (rx_data),
    .rx_charisk      (rx_charisk),
    .align_status    (align_status)
  );

  always #2 mgt_clk = ~mgt_clk;

  // Taps 16, 14, 13, 11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int b = 0; b < n; b++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  // ------------------------------
  // Column stream and lane skew
  // ------------------------------

  always @(posedge mgt_clk) begin : drive
    xaui_pkg::lane_word_t  col_d;
    xaui_pkg::lane_flags_t col_k;
    xaui_pkg::lane_word_t  raw_d;
    xaui_pkg::lane_flags_t raw_k;
    if (reset) a_sent = 0;
    if (col_pos == 0) begin
      col_d = {xaui_pkg::lane_count{xaui_pkg::sym_a}}; // Every 16th column is /A/
      col_k = '1;
      a_sent++;
    end else begin
      col_d = rand_bits(32);
      col_k = '0;
    end
    for (int s = 7; s > 0; s--) begin
      hist_d[s] = hist_d[s-1];
      hist_k[s] = hist_k[s-1];
    end
    hist_d[0] = col_d;
    hist_k[0] = col_k;
    for (int i = 0; i < xaui_pkg::lane_count; i++) begin
      raw_d[8*i +: 8] = hist_d[skew[i]][8*i +: 8];
      raw_k[i]        = hist_k[skew[i]][i];
    end
    mgt_rxdata      <= raw_d;
    mgt_rxcharisk   <= raw_k;
    mgt_disp_err    <= err_req ? 4'b0001 : 4'b0000; // Errors ride on lane 0
    mgt_sync_status <= sync_req ? ~(4'b0001 << sync_lane) : 4'b1111;
    err_req  = 0;
    sync_req = 0;
    exp_q.push_back({col_k, col_d});
    if (!synced && exp_q.size() > 8) void'(exp_q.pop_front());
    col_pos = (col_pos + 1) % 16;
  end

  // ------------------------------
  // Checks and scoreboard
  // ------------------------------

  assert property (@(posedge mgt_clk) disable iff (reset) !align_status || a_sent >= 4)
    else report_fail("align_status rose before four /A/ columns were sent");

  assert property (@(posedge mgt_clk) disable iff (reset) !hold_high || align_status)
    else report_fail($sformatf("Mismatch in %s: expected align_status 1, actual 0",
                               test_name));

  assert property (@(posedge mgt_clk) disable iff (reset) !hold_low || !align_status)
    else report_fail($sformatf("Mismatch in %s: expected align_status 0, actual 1",
                               test_name));

  always @(negedge mgt_clk) begin : check
    logic [35:0] exp;
    cyc++;
    if (cyc >= cycle_limit) report_fail("Timeout, the run exceeded its cycle limit");
    if (!reset) begin
      if (!align_status) begin
        synced = 0;
      end else if (!synced) begin
        if (rx_charisk == '1 && rx_data == {xaui_pkg::lane_count{xaui_pkg::sym_a}}) begin
          while (exp_q.size() > 0 && exp_q[0][35:32] != 4'hF) void'(exp_q.pop_front());
          assert (exp_q.size() > 0) else report_fail("No /A/ column left in the scoreboard");
          void'(exp_q.pop_front()); // Lock onto the first aligned /A/ column
          synced = 1;
        end
      end else begin
        assert (exp_q.size() > 0) else report_fail("Scoreboard queue ran empty");
        exp = exp_q.pop_front();
        assert ({rx_charisk, rx_data} == exp)
          else report_fail($sformatf("Mismatch in %s: expected %h, actual %h", test_name,
                                     exp, {rx_charisk, rx_data}));
      end
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------

  task automatic do_reset();
    @(posedge mgt_clk);
    reset <= 1'b1;
    repeat (4) @(posedge mgt_clk);
    reset <= 1'b0;
    @(negedge mgt_clk);
  endtask

  task automatic wait_align();
    int mark;
    mark = a_sent;
    while (!align_status) begin
      @(negedge mgt_clk);
      if (a_sent - mark > 6) report_fail("align_status did not rise within six /A/ periods");
    end
  endtask

  task automatic wait_pos(input int p);
    do @(negedge mgt_clk); while (col_pos != p);
  endtask

  task automatic expect_fall(input int limit);
    int n;
    n = 0;
    while (align_status && n < limit) begin
      @(negedge mgt_clk);
      n++;
    end
    assert (!align_status)
      else report_fail($sformatf("Mismatch in %s: expected align_status 0, actual 1", test_name));
  endtask

  task automatic run_stable(input int periods);
    hold_high = 1;
    repeat (periods * 16) @(negedge mgt_clk);
    hold_high = 0;
    assert (synced) else report_fail("Scoreboard never locked onto an aligned /A/ column");
  endtask

  initial begin
    for (int s = 0; s < 8; s++) begin
      hist_d[s] = '0;
      hist_k[s] = '0;
    end
    for (int i = 0; i < xaui_pkg::lane_count; i++) skew[i] = 0;
    for (int t = 1; t <= 3; t++) begin
      test_name = $sformatf("acquire_%0d", t);
      for (int i = 0; i < xaui_pkg::lane_count; i++) skew[i] = int'(rand_bits(2));
      do_reset();
      wait_align();
      run_stable(4);
    end

    test_name = "sync_drop";
    wait_pos(5);
    sync_lane = 2'(rand_bits(2));
    sync_req  = 1;
    expect_fall(4);
    wait_align();
    run_stable(4);

    test_name = "disp_err";
    wait_pos(3);
    err_req = 1;
    wait_pos(5);
    err_req = 1;
    wait_pos(7);
    err_req = 1;
    hold_high = 1; // Three errors only reach align_acquired_4
    wait_pos(13);
    err_req = 1;
    wait_pos(0);
    hold_high = 0;
    expect_fall(1 + xaui_pkg::max_skew);
    wait_align();
    run_stable(1);
    wait_pos(3);
    err_req = 1;
    wait_pos(5);
    err_req = 1;
    wait_pos(7);
    err_req = 1;
    hold_high = 1;
    wait_pos(1);
    wait_pos(8);
    err_req = 1; // The /A/ column in between stepped the FSM back up
    wait_pos(15);
    run_stable(1);

    test_name = "skew_too_large";
    skew[0] = 4;
    for (int i = 1; i < xaui_pkg::lane_count; i++) skew[i] = 0;
    do_reset();
    hold_low = 1;
    repeat (20 * 16) @(negedge mgt_clk);
    hold_low = 0;

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

/* xaui_pkg.sv */
`default_nettype none

package xaui_pkg;

  // ------------------------------
  // Lane geometry
  // ------------------------------

  localparam int lane_count = 4;

  typedef logic [8*lane_count-1:0] lane_word_t; // Lane 0 in the low byte
  typedef logic [lane_count-1:0]   lane_flags_t; // One bit per lane

  // ------------------------------
  // Code groups
  // ------------------------------

  localparam logic [7:0] sym_a = 8'h7C; // K28.3 alignment character

  // ------------------------------
  // Deskew range and alignment FSM
  // ------------------------------

  localparam int max_skew = 3; // Largest correctable lane skew in cycles

  typedef logic [1:0] lane_delay_t; // Per-lane delay, 0 up to max_skew

  // Encoding keeps all acquired states in the upper half
  typedef enum logic [2:0] {
    loss_of_alignment = 3'd0,
    align_detect_1    = 3'd1,
    align_detect_2    = 3'd2,
    align_detect_3    = 3'd3,
    align_acquired_1  = 3'd4,
    align_acquired_2  = 3'd5,
    align_acquired_3  = 3'd6,
    align_acquired_4  = 3'd7
  } align_state_t;

endpackage

`default_nettype wire

/* xaui_rx_align.f */
xaui_pkg.sv
lane_bus_if.sv
lane_deskew.sv
deskew_state.sv
xaui_rx_align.sv
tb_xaui_rx_align.sv

/* xaui_rx_align.sv */
`timescale 1ns/10ps
`default_nettype none

module xaui_rx_align (
  input  logic                  mgt_clk,
  input  logic                  reset,
  input  xaui_pkg::lane_word_t  mgt_rxdata,
  input  xaui_pkg::lane_flags_t mgt_rxcharisk,
  input  xaui_pkg::lane_flags_t mgt_sync_status,
  input  xaui_pkg::lane_flags_t mgt_disp_err,
  output xaui_pkg::lane_word_t  rx_data,
  output xaui_pkg::lane_flags_t rx_charisk,
  output logic                  align_status
);

  logic enable_deskew; // Measurement window allowed while out of alignment

  lane_bus_if raw_bus ();
  lane_bus_if aligned_bus ();

  // ------------------------------
  // Transceiver side
  // ------------------------------

  assign raw_bus.data        = mgt_rxdata;
  assign raw_bus.charisk     = mgt_rxcharisk;
  assign raw_bus.disp_err    = mgt_disp_err;
  assign raw_bus.sync_status = mgt_sync_status;

  lane_deskew u_lane_deskew (
    .mgt_clk       (mgt_clk),
    .reset         (reset),
    .enable_deskew (enable_deskew),
    .raw           (raw_bus.sink),
    .aligned       (aligned_bus.source)
  );

  deskew_state u_deskew_state (
    .mgt_clk       (mgt_clk),
    .reset         (reset),
    .lanes         (aligned_bus.sink),
    .align_status  (align_status),
    .enable_deskew (enable_deskew)
  );

  // Aligned column out
  assign rx_data    = aligned_bus.data;
  assign rx_charisk = aligned_bus.charisk;

endmodule

`default_nettype wire
